// File: verilog/route_pkg.sv
package route_pkg;

    // Router geometry
    localparam int num_inputs = 4;
    localparam int src_width = $clog2(num_inputs);

    // Lookup key widths
    localparam int log_ctx = 2;
    localparam int addr_width = 4;

    // Table size per routing table, two halves of contexts x destinations
    localparam int log_table = 1 + log_ctx + addr_width;
    localparam int table_words = 1 << log_table;

    // Configuration stream word, only the low entry bits are stored
    localparam int cfg_width = 16;

    // Next-hop entry layout
    localparam int entry_width = 9;
    localparam int route_valid_bit = 8;
    localparam int port_width = 2;
    localparam int num_outputs = 1 << port_width;

    typedef logic [log_ctx-1:0] ccid_t;
    typedef logic [addr_width-1:0] dest_t;
    typedef logic [entry_width-1:0] entry_t;

endpackage

// File: verilog/lookup_if.sv
interface lookup_if
    import route_pkg::*;
();

    // Port A results
    logic valid_a;
    ccid_t ccid_a;
    entry_t nexthop_a;

    // Port B results
    logic valid_b;
    ccid_t ccid_b;
    entry_t nexthop_b;

    // Driven by the routing table
    modport tbl (
        output valid_a,
        output ccid_a,
        output nexthop_a,
        output valid_b,
        output ccid_b,
        output nexthop_b
    );

    // Consumed by the route arbiter
    modport arbiter (
        input valid_a,
        input ccid_a,
        input nexthop_a,
        input valid_b,
        input ccid_b,
        input nexthop_b
    );

endinterface

// File: verilog/dual_bram.sv
module dual_bram
    import route_pkg::*;
(
    input  logic                 clock,
    input  logic                 enable,
    input  logic                 wen,
    input  logic [log_table-1:0] waddr,
    input  entry_t               din,
    input  logic [log_table-1:0] raddr_a,
    input  logic [log_table-1:0] raddr_b,
    output entry_t               dout_a,
    output entry_t               dout_b
);

    entry_t mem [table_words];

    // Configuration writes are not held by the lookup stall
    always_ff @(posedge clock)
    begin
        if (wen)
        begin
            mem[waddr] <= din;
        end
    end

    // Two registered read ports sharing the stall enable
    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            dout_a <= mem[raddr_a];
            dout_b <= mem[raddr_b];
        end
    end

endmodule

// File: verilog/routing_table.sv
module routing_table
    import route_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,

    // Configuration chain
    input  logic [cfg_width-1:0] cfg_in,
    input  logic                 cfg_in_valid,
    output logic [cfg_width-1:0] cfg_out,
    output logic                 cfg_out_valid,

    // Lookup port A, lower half of the memory
    input  logic                 req_valid_a,
    input  ccid_t                ccid_a,
    input  dest_t                dest_a,

    // Lookup port B, upper half of the memory
    input  logic                 req_valid_b,
    input  ccid_t                ccid_b,
    input  dest_t                dest_b,

    lookup_if.tbl                lookup
);

    logic [log_table:0] words_loaded;
    logic config_done;
    logic load_wen;
    logic [log_table-1:0] raddr_a;
    logic [log_table-1:0] raddr_b;
    logic valid_a_q;
    logic valid_b_q;
    ccid_t ccid_a_q;
    ccid_t ccid_b_q;
    entry_t dout_a;
    entry_t dout_b;

    assign config_done = (words_loaded == (log_table + 1)'(table_words));
    assign load_wen = cfg_in_valid & ~config_done;

    // Stream passes on untouched once this table is full
    assign cfg_out = cfg_in;
    assign cfg_out_valid = cfg_in_valid & config_done;

    assign raddr_a = {1'b0, ccid_a, dest_a};
    assign raddr_b = {1'b1, ccid_b, dest_b};

    // Word counter doubles as the write address
    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            words_loaded <= '0;
        end
        else if (load_wen)
        begin
            words_loaded <= words_loaded + 1'b1;
        end
    end

    dual_bram u_bram (
        .clock   (clock),
        .enable  (enable),
        .wen     (load_wen),
        .waddr   (words_loaded[log_table-1:0]),
        .din     (cfg_in[entry_width-1:0]),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .dout_a  (dout_a),
        .dout_b  (dout_b)
    );

    // Align ccid and valid with the one cycle RAM read
    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            valid_a_q <= 1'b0;
            valid_b_q <= 1'b0;
            ccid_a_q <= '0;
            ccid_b_q <= '0;
        end
        else if (enable)
        begin
            // No lookups before the table holds its entries
            valid_a_q <= req_valid_a & config_done;
            valid_b_q <= req_valid_b & config_done;
            ccid_a_q <= ccid_a;
            ccid_b_q <= ccid_b;
        end
    end

    assign lookup.valid_a = valid_a_q;
    assign lookup.ccid_a = ccid_a_q;
    assign lookup.nexthop_a = dout_a;
    assign lookup.valid_b = valid_b_q;
    assign lookup.ccid_b = ccid_b_q;
    assign lookup.nexthop_b = dout_b;

endmodule

// File: verilog/route_arbiter.sv
module route_arbiter
    import route_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    enable,

    // Results from table 0 (inputs 0, 1) and table 1 (inputs 2, 3)
    lookup_if.arbiter                               lookup_lo,
    lookup_if.arbiter                               lookup_hi,

    // Per input responses
    output logic   [num_inputs-1:0]                 resp_valid,
    output ccid_t  [num_inputs-1:0]                 resp_ccid,
    output entry_t [num_inputs-1:0]                 resp_nexthop,
    output logic   [num_inputs-1:0]                 resp_grant,

    // Per output port winner
    output logic   [num_outputs-1:0]                out_valid,
    output logic   [num_outputs-1:0][src_width-1:0] out_src
);

    logic   [num_inputs-1:0] in_valid;
    ccid_t  [num_inputs-1:0] in_ccid;
    entry_t [num_inputs-1:0] in_nexthop;

    // req[p][i] set when input i wants output p
    logic [num_outputs-1:0][num_inputs-1:0] req;
    logic [num_outputs-1:0][src_width-1:0] ptr;
    logic [num_outputs-1:0] win_valid;
    logic [num_outputs-1:0][src_width-1:0] win_src;
    logic [num_inputs-1:0] grant;

    // Flatten both tables into input order
    assign in_valid = {lookup_hi.valid_b, lookup_hi.valid_a,
                       lookup_lo.valid_b, lookup_lo.valid_a};
    assign in_ccid = {lookup_hi.ccid_b, lookup_hi.ccid_a,
                      lookup_lo.ccid_b, lookup_lo.ccid_a};
    assign in_nexthop = {lookup_hi.nexthop_b, lookup_hi.nexthop_a,
                         lookup_lo.nexthop_b, lookup_lo.nexthop_a};

    always_comb
    begin
        for (int p = 0; p < num_outputs; p++)
        begin
            for (int i = 0; i < num_inputs; i++)
            begin
                req[p][i] = in_valid[i]
                          & in_nexthop[i][route_valid_bit]
                          & (in_nexthop[i][port_width-1:0] == port_width'(p));
            end
        end
    end

    // First requester at or after the pointer wins
    always_comb
    begin
        logic [src_width-1:0] idx;

        idx = '0;
        for (int p = 0; p < num_outputs; p++)
        begin
            win_valid[p] = 1'b0;
            win_src[p] = '0;
            for (int k = 0; k < num_inputs; k++)
            begin
                idx = ptr[p] + src_width'(k);
                if (!win_valid[p] && req[p][idx])
                begin
                    win_valid[p] = 1'b1;
                    win_src[p] = idx;
                end
            end
        end
    end

    // An input requests one port at most, so its grant is any win naming it
    always_comb
    begin
        grant = '0;
        for (int p = 0; p < num_outputs; p++)
        begin
            if (win_valid[p])
            begin
                grant[win_src[p]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            resp_valid <= '0;
            resp_grant <= '0;
            out_valid <= '0;
            ptr <= '0;
        end
        else if (enable)
        begin
            resp_valid <= in_valid;
            resp_grant <= grant;
            out_valid <= win_valid;
            for (int p = 0; p < num_outputs; p++)
            begin
                if (win_valid[p])
                begin
                    ptr[p] <= win_src[p] + 1'b1;
                end
            end
        end
    end

    // Payload
    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            resp_ccid <= in_ccid;
            resp_nexthop <= in_nexthop;
            out_src <= win_src;
        end
    end

endmodule

// File: verilog/route_unit.sv
module route_unit
    import route_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    enable,

    // Configuration chain
    input  logic   [cfg_width-1:0]                  cfg_in,
    input  logic                                    cfg_in_valid,
    output logic   [cfg_width-1:0]                  cfg_out,
    output logic                                    cfg_out_valid,

    // Lookup requests
    input  logic   [num_inputs-1:0]                 req_valid,
    input  ccid_t  [num_inputs-1:0]                 req_ccid,
    input  dest_t  [num_inputs-1:0]                 req_dest,

    // Responses
    output logic   [num_inputs-1:0]                 resp_valid,
    output ccid_t  [num_inputs-1:0]                 resp_ccid,
    output entry_t [num_inputs-1:0]                 resp_nexthop,
    output logic   [num_inputs-1:0]                 resp_grant,
    output logic   [num_outputs-1:0]                out_valid,
    output logic   [num_outputs-1:0][src_width-1:0] out_src
);

    // Chain link from table 0 to table 1
    logic [cfg_width-1:0] cfg_mid;
    logic cfg_mid_valid;

    lookup_if lookup_lo ();
    lookup_if lookup_hi ();

    // Table 0 loads first and serves inputs 0 and 1
    routing_table u_table_lo (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .cfg_in        (cfg_in),
        .cfg_in_valid  (cfg_in_valid),
        .cfg_out       (cfg_mid),
        .cfg_out_valid (cfg_mid_valid),
        .req_valid_a   (req_valid[0]),
        .ccid_a        (req_ccid[0]),
        .dest_a        (req_dest[0]),
        .req_valid_b   (req_valid[1]),
        .ccid_b        (req_ccid[1]),
        .dest_b        (req_dest[1]),
        .lookup        (lookup_lo)
    );

    // Table 1 takes the next 128 words, serves inputs 2 and 3
    routing_table u_table_hi (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .cfg_in        (cfg_mid),
        .cfg_in_valid  (cfg_mid_valid),
        .cfg_out       (cfg_out),
        .cfg_out_valid (cfg_out_valid),
        .req_valid_a   (req_valid[2]),
        .ccid_a        (req_ccid[2]),
        .dest_a        (req_dest[2]),
        .req_valid_b   (req_valid[3]),
        .ccid_b        (req_ccid[3]),
        .dest_b        (req_dest[3]),
        .lookup        (lookup_hi)
    );

    route_arbiter u_arbiter (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .lookup_lo    (lookup_lo),
        .lookup_hi    (lookup_hi),
        .resp_valid   (resp_valid),
        .resp_ccid    (resp_ccid),
        .resp_nexthop (resp_nexthop),
        .resp_grant   (resp_grant),
        .out_valid    (out_valid),
        .out_src      (out_src)
    );

endmodule

// File: sim/route_unit_sva.sv
module route_unit_sva
    import route_pkg::*;
(
    input logic                                    clock,
    input logic                                    reset,
    input logic   [num_inputs-1:0]                 resp_valid,
    input entry_t [num_inputs-1:0]                 resp_nexthop,
    input logic   [num_inputs-1:0]                 resp_grant,
    input logic   [num_outputs-1:0]                out_valid,
    input logic   [num_outputs-1:0][src_width-1:0] out_src
);

    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;

    // wants[p][i] set when registered response i is routed to output p
    logic [num_outputs-1:0][num_inputs-1:0] wants;

    always_comb
    begin
        for (int p = 0; p < num_outputs; p++)
        begin
            for (int i = 0; i < num_inputs; i++)
            begin
                wants[p][i] = resp_valid[i]
                            & resp_nexthop[i][route_valid_bit]
                            & (resp_nexthop[i][port_width-1:0] == port_width'(p));
            end
        end
    end

    for (genvar p = 0; p < num_outputs; p++)
    begin : g_output
        winner_routed: assert property (@(posedge clock) disable iff (reset)
            out_valid[p] |-> wants[p][out_src[p]] && resp_grant[out_src[p]])
        else
        begin
            $error("output %0d names an input that is not a granted requester", p);
            error_count++;
        end

        single_grant: assert property (@(posedge clock) disable iff (reset)
            $countones(wants[p] & resp_grant) <= 1)
        else
        begin
            $error("output %0d granted to more than one input", p);
            error_count++;
        end

        // Work conserving
        never_idle: assert property (@(posedge clock) disable iff (reset)
            (|wants[p]) |-> out_valid[p])
        else
        begin
            $error("output %0d idle while an input requests it", p);
            error_count++;
        end
    end

    for (genvar i = 0; i < num_inputs; i++)
    begin : g_input
        grant_routable: assert property (@(posedge clock) disable iff (reset)
            resp_grant[i] |-> resp_valid[i] && resp_nexthop[i][route_valid_bit])
        else
        begin
            $error("input %0d granted without a valid route", i);
            error_count++;
        end
    end

endmodule

bind route_arbiter route_unit_sva u_sva (
    .clock        (clock),
    .reset        (reset),
    .resp_valid   (resp_valid),
    .resp_nexthop (resp_nexthop),
    .resp_grant   (resp_grant),
    .out_valid    (out_valid),
    .out_src      (out_src)
);

// File: sim/tb_route_unit.sv
module tb_route_unit
    import route_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic clock;
    logic reset;
    logic enable;
    logic [cfg_width-1:0] cfg_in;
    logic cfg_in_valid;
    logic [cfg_width-1:0] cfg_out;
    logic cfg_out_valid;
    logic [num_inputs-1:0] req_valid;
    ccid_t [num_inputs-1:0] req_ccid;
    dest_t [num_inputs-1:0] req_dest;
    logic [num_inputs-1:0] resp_valid;
    ccid_t [num_inputs-1:0] resp_ccid;
    entry_t [num_inputs-1:0] resp_nexthop;
    logic [num_inputs-1:0] resp_grant;
    logic [num_outputs-1:0] out_valid;
    logic [num_outputs-1:0][src_width-1:0] out_src;

    // Reference copy of both tables, table 0 first
    logic [cfg_width-1:0] model [2 * table_words];
    integer seed;
    int cycle_count = 0;
    int cfg_count = 0;
    logic stalled;

    // Expected responses, one and two enabled cycles behind the requests
    logic [num_inputs-1:0] exp1_valid;
    logic [num_inputs-1:0] exp2_valid;
    ccid_t [num_inputs-1:0] exp1_ccid;
    ccid_t [num_inputs-1:0] exp2_ccid;
    entry_t [num_inputs-1:0] exp1_entry;
    entry_t [num_inputs-1:0] exp2_entry;
    logic [63:0] out_now;
    logic [63:0] out_last;

    route_unit u_dut (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .cfg_in        (cfg_in),
        .cfg_in_valid  (cfg_in_valid),
        .cfg_out       (cfg_out),
        .cfg_out_valid (cfg_out_valid),
        .req_valid     (req_valid),
        .req_ccid      (req_ccid),
        .req_dest      (req_dest),
        .resp_valid    (resp_valid),
        .resp_ccid     (resp_ccid),
        .resp_nexthop  (resp_nexthop),
        .resp_grant    (resp_grant),
        .out_valid     (out_valid),
        .out_src       (out_src)
    );

    always #5 clock = ~clock;

    task automatic report_failure(string what);
        $display("ERROR: %s", what);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] want);
        $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // Inputs 2 and 3 live in table 1, odd inputs in the upper half
    function automatic entry_t model_entry(int port, ccid_t ccid, dest_t dest);
        int idx;
        idx = (port / 2) * table_words;
        if (port % 2 == 1)
        begin
            idx = idx + table_words / 2;
        end
        idx = idx + int'(ccid) * (1 << addr_width) + int'(dest);
        return model[idx][entry_width-1:0];
    endfunction

    // Reset 16 + load about 350 + lookups 600 + round-robin 20, doubled
    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= 2000)
        begin
            report_failure("run timed out before all tests finished");
        end
        if (reset)
        begin
            exp1_valid = '0;
            exp2_valid = '0;
            stalled = 1'b0;
        end
        else
        begin
            stalled = !enable;
            if (cfg_in_valid)
            begin
                cfg_count++;
            end
            if (enable)
            begin
                exp2_valid = exp1_valid;
                exp2_ccid = exp1_ccid;
                exp2_entry = exp1_entry;
                exp1_valid = req_valid;
                exp1_ccid = req_ccid;
                for (int i = 0; i < num_inputs; i++)
                begin
                    exp1_entry[i] = model_entry(i, req_ccid[i], req_dest[i]);
                end
            end
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (cfg_count < 2 * table_words)
            begin
                assert (cfg_out_valid === 1'b0)
                else report_mismatch("cfg_out_valid", 64'(cfg_out_valid), 64'(0));
            end
            else
            begin
                assert (cfg_out_valid === cfg_in_valid)
                else report_mismatch("cfg_out_valid", 64'(cfg_out_valid), 64'(cfg_in_valid));
                assert (cfg_out === cfg_in)
                else report_mismatch("cfg_out", 64'(cfg_out), 64'(cfg_in));
            end
            assert (resp_valid === exp2_valid)
            else report_mismatch("resp_valid", 64'(resp_valid), 64'(exp2_valid));
            for (int i = 0; i < num_inputs; i++)
            begin
                if (exp2_valid[i])
                begin
                    assert (resp_ccid[i] === exp2_ccid[i])
                    else report_mismatch($sformatf("resp_ccid[%0d]", i),
                                         64'(resp_ccid[i]), 64'(exp2_ccid[i]));
                    assert (resp_nexthop[i] === exp2_entry[i])
                    else report_mismatch($sformatf("resp_nexthop[%0d]", i),
                                         64'(resp_nexthop[i]), 64'(exp2_entry[i]));
                end
            end
            out_now = {resp_valid, resp_grant, out_valid, resp_ccid, out_src, resp_nexthop};
            if (stalled)
            begin
                assert (out_now === out_last)
                else report_mismatch("outputs during stall", out_now, out_last);
            end
            out_last = out_now;
            assert (u_dut.u_arbiter.u_sva.error_count == 0)
            else report_failure("an arbitration assertion failed");
        end
    end

    // Eight words past the tables exercise the pass-through
    task automatic load_tables();
        int k;
        k = 0;
        while (k < 2 * table_words + 8)
        begin
            @(posedge clock);
            #1;
            cfg_in_valid = (($random(seed) & 3) != 0);
            cfg_in = (k < 2 * table_words) ? model[k] : cfg_width'($random(seed));
            if (cfg_in_valid)
            begin
                k++;
            end
        end
        @(posedge clock);
        #1;
        cfg_in_valid = 1'b0;
    endtask

    task automatic run_lookups(int cycles, logic with_stalls);
        int stall_left;
        stall_left = 0;
        repeat (cycles)
        begin
            @(posedge clock);
            #1;
            enable = 1'b1;
            if (stall_left > 0)
            begin
                enable = 1'b0;
                stall_left--;
            end
            else if (with_stalls && (($random(seed) & 3) == 0))
            begin
                enable = 1'b0;
                stall_left = int'($unsigned($random(seed)) % 5);
            end
            for (int i = 0; i < num_inputs; i++)
            begin
                req_valid[i] = 1'($random(seed));
                req_ccid[i] = ccid_t'($random(seed));
                req_dest[i] = dest_t'($random(seed));
            end
        end
    endtask

    // Inputs 0 and 1 hold requests to one output and should take turns
    task automatic check_round_robin();
        int pair_a;
        int pair_b;
        int rr_port;
        logic found;
        logic [src_width-1:0] last_src;
        entry_t ea;
        entry_t eb;
        found = 1'b0;
        pair_a = 0;
        pair_b = 0;
        rr_port = 0;
        for (int a = 0; a < table_words / 2; a++)
        begin
            for (int b = 0; b < table_words / 2; b++)
            begin
                ea = model_entry(0, ccid_t'(a >> addr_width), dest_t'(a));
                eb = model_entry(1, ccid_t'(b >> addr_width), dest_t'(b));
                if (!found && ea[route_valid_bit] && eb[route_valid_bit]
                    && ea[port_width-1:0] == eb[port_width-1:0])
                begin
                    found = 1'b1;
                    pair_a = a;
                    pair_b = b;
                    rr_port = int'(ea[port_width-1:0]);
                end
            end
        end
        if (!found)
        begin
            report_failure("no two table entries share an output port");
        end
        @(posedge clock);
        #1;
        enable = 1'b1;
        req_valid = 4'b0011;
        req_ccid[0] = ccid_t'(pair_a >> addr_width);
        req_dest[0] = dest_t'(pair_a);
        req_ccid[1] = ccid_t'(pair_b >> addr_width);
        req_dest[1] = dest_t'(pair_b);
        repeat (2) @(posedge clock);
        last_src = '0;
        for (int n = 0; n < 10; n++)
        begin
            @(negedge clock);
            assert (out_valid[rr_port] === 1'b1)
            else report_failure("contended output left idle");
            if (n > 0)
            begin
                assert (out_src[rr_port] === (last_src ^ 1'b1))
                else report_mismatch("out_src", 64'(out_src[rr_port]), 64'(last_src ^ 1'b1));
            end
            last_src = out_src[rr_port];
        end
        @(posedge clock);
        #1;
        req_valid = '0;
    endtask

    initial
    begin
        seed = 29;
        clock = 1'b0;
        reset = 1'b1;
        enable = 1'b1;
        cfg_in = '0;
        cfg_in_valid = 1'b0;
        req_valid = '0;
        req_ccid = '0;
        req_dest = '0;
        for (int k = 0; k < 2 * table_words; k++)
        begin
            model[k] = cfg_width'($random(seed));
        end
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        load_tables();
        run_lookups(300, 1'b0);
        run_lookups(300, 1'b1);
        check_round_robin();
        repeat (4) @(posedge clock);
        if (u_dut.u_arbiter.u_sva.error_count != 0)
        begin
            report_failure("an arbitration assertion failed");
        end
        else
        begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: route_unit.f
verilog/route_pkg.sv
verilog/lookup_if.sv
verilog/dual_bram.sv
verilog/routing_table.sv
verilog/route_arbiter.sv
verilog/route_unit.sv
sim/route_unit_sva.sv
sim/tb_route_unit.sv

// File: Makefile
TOP = tb_route_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module route_unit \
		-f route_unit.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f route_unit.f -o sim_route_unit
	./obj_dir/sim_route_unit +verilator+error+limit+100 2>&1 | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
